// ==== rtl/hit_miss_pkg.sv ====
package hit_miss_pkg;

  //////////////////////////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////////////////////////

  // address split: tag | index | offset
  localparam int unsigned ADDR_W   = 16;
  localparam int unsigned OFFSET_W = 4;
  localparam int unsigned INDEX_W  = 4;
  localparam int unsigned TAG_W    = ADDR_W - OFFSET_W - INDEX_W;
  localparam int unsigned NUM_SETS = 2 ** INDEX_W;
  localparam int unsigned NUM_WAYS = 2;
  localparam int unsigned ID_W     = 2;
  // a miss counter saturates at its all-ones value
  localparam int unsigned CNT_W    = 2;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [ID_W-1:0]     id_t;
  // one-hot way select
  typedef logic [NUM_WAYS-1:0] way_t;
  typedef logic [CNT_W-1:0]    cnt_t;

  // controller sequence
  typedef enum logic [1:0] {INIT, IDLE, LOOKUP, ROUTE} ctrl_state_e;

endpackage

// ==== rtl/hit_miss_ctrl.sv ====
module hit_miss_ctrl import hit_miss_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  // incoming descriptor
  input  logic   valid_i,
  input  addr_t  addr_i,
  input  id_t    id_i,
  input  logic   rw_i,
  output logic   ready_o,
  // hand-off paths
  output logic   hit_valid_o,
  input  logic   hit_ready_i,
  output logic   miss_valid_o,
  input  logic   miss_ready_i,
  output addr_t  out_addr_o,
  output id_t    out_id_o,
  output logic   out_rw_o,
  output way_t   way_o,
  output logic   refill_o,
  output logic   evict_o,
  output tag_t   evict_tag_o,
  // tag store
  input  logic   init_done_i,
  input  way_t   way_i,
  input  logic   hit_i,
  input  logic   evict_i,
  input  tag_t   evict_tag_i,
  output logic   lookup_o,
  output index_t index_o,
  output tag_t   tag_o,
  output logic   dirty_o,
  output logic   commit_o,
  // lock table
  input  logic   locked_i,
  output logic   lock_set_o,
  output index_t lock_index_o,
  output way_t   lock_way_o,
  // miss counters
  input  logic   to_miss_i,
  input  logic   full_i,
  output logic   cnt_up_o,
  output id_t    cnt_id_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // descriptor held in the unit
  addr_t addr_q;
  id_t   id_q;
  logic  rw_q;

  // registered tag store answer
  way_t  way_q;
  logic  hit_q;
  logic  evict_q;
  tag_t  evict_tag_q;

  logic  stall;
  logic  to_hit;
  logic  xfer_hit;
  logic  xfer_miss;

  //////////////////////////////////////////////////////////////////////
  // acceptance and lookup request
  //////////////////////////////////////////////////////////////////////

  // only one descriptor in flight, so accept in IDLE only
  assign ready_o  = (state_q == IDLE) & valid_i;
  // lookup goes out in the accept cycle, straight from the input address
  assign lookup_o = ready_o;
  assign index_o  = addr_i[OFFSET_W +: INDEX_W];
  assign tag_o    = addr_i[OFFSET_W + INDEX_W +: TAG_W];
  // writes mark the line dirty
  assign dirty_o  = rw_i;

  //////////////////////////////////////////////////////////////////////
  // routing
  //////////////////////////////////////////////////////////////////////

  // locked line or full id counter holds the descriptor back
  assign stall  = locked_i | full_i;
  // a hit takes the bypass only when no earlier miss of its id is pending
  assign to_hit = hit_q & ~to_miss_i;

  assign hit_valid_o  = (state_q == ROUTE) & ~stall & to_hit;
  assign miss_valid_o = (state_q == ROUTE) & ~stall & ~to_hit;
  assign xfer_hit     = hit_valid_o & hit_ready_i;
  assign xfer_miss    = miss_valid_o & miss_ready_i;

  // descriptor outputs come from registers and hold under back-pressure
  assign out_addr_o  = addr_q;
  assign out_id_o    = id_q;
  assign out_rw_o    = rw_q;
  assign way_o       = way_q;
  // forced misses keep refill low, the line is already present
  assign refill_o    = ~hit_q;
  assign evict_o     = evict_q;
  assign evict_tag_o = evict_tag_q;

  // lock the line on any hand-off
  assign lock_set_o   = xfer_hit | xfer_miss;
  assign lock_index_o = addr_q[OFFSET_W +: INDEX_W];
  assign lock_way_o   = way_q;
  // count every miss path transfer against the id
  assign cnt_up_o = xfer_miss;
  assign cnt_id_o = id_q;
  // victim fill on miss path, dirty update on hit write
  assign commit_o = xfer_miss | (xfer_hit & rw_q);

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      INIT:    if (init_done_i) state_d = IDLE;
      IDLE:    if (ready_o) state_d = LOOKUP;
      // tag store answer is valid here, captured below
      LOOKUP:  state_d = ROUTE;
      ROUTE:   if (xfer_hit | xfer_miss) state_d = IDLE;
      default: state_d = INIT;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= INIT;
    end else begin
      state_q <= state_d;
    end
  end

  // payload registers
  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      addr_q <= addr_i;
      id_q   <= id_i;
      rw_q   <= rw_i;
    end
    if (state_q == LOOKUP) begin
      way_q       <= way_i;
      hit_q       <= hit_i;
      evict_q     <= evict_i;
      evict_tag_q <= evict_tag_i;
    end
  end

endmodule

// ==== rtl/tag_store.sv ====
module tag_store import hit_miss_pkg::*; #(
  // cycles of the clear sweep, at least NUM_SETS
  parameter int unsigned SWEEP_LEN = 16
) (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   lookup_i,
  input  index_t index_i,
  input  tag_t   tag_i,
  input  logic   dirty_i,
  input  logic   commit_i,
  output logic   init_done_o,
  output way_t   way_o,
  output logic   hit_o,
  output logic   evict_o,
  output tag_t   evict_tag_o
);

  localparam int unsigned SWEEP_W = (SWEEP_LEN > 1) ? $clog2(SWEEP_LEN) : 1;

  // storage arrays
  way_t   valid_q [NUM_SETS];
  way_t   dirty_q [NUM_SETS];
  tag_t   tag_q   [NUM_SETS][NUM_WAYS];

  logic [SWEEP_W-1:0] sweep_cnt;
  index_t             sweep_idx;
  // victim pointer, one-hot, global over all sets
  way_t               rr_q;

  // request kept from lookup until commit
  index_t req_index_q;
  tag_t   req_tag_q;
  logic   req_dirty_q;

  // lookup of the addressed set
  way_t   row_valid;
  way_t   row_dirty;
  way_t   match;
  way_t   free;
  way_t   victim;
  tag_t   victim_tag;
  logic   lookup_hit;

  //////////////////////////////////////////////////////////////////////
  // lookup and victim choice
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    row_valid  = valid_q[index_i];
    row_dirty  = dirty_q[index_i];
    match      = '0;
    victim_tag = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      match[w] = row_valid[w] && (tag_q[index_i][w] == tag_i);
    end
    lookup_hit = |match;
    // lowest invalid way first, else round robin
    free   = ~row_valid;
    victim = (|free) ? (free & (~free + way_t'(1))) : rr_q;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (victim[w]) victim_tag = tag_q[index_i][w];
    end
  end

  // answer appears one cycle after the request
  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      req_index_q <= index_i;
      req_tag_q   <= tag_i;
      req_dirty_q <= dirty_i;
      hit_o       <= lookup_hit;
      way_o       <= lookup_hit ? match : victim;
      // evict only a valid dirty victim
      evict_o     <= ~lookup_hit & (|(victim & row_valid & row_dirty));
      evict_tag_o <= lookup_hit ? '0 : victim_tag;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sweep counter and victim pointer
  //////////////////////////////////////////////////////////////////////

  assign sweep_idx = index_t'(sweep_cnt);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sweep_cnt   <= '0;
      init_done_o <= 1'b0;
      rr_q        <= way_t'(1);
    end else begin
      if (!init_done_o) begin
        sweep_cnt <= sweep_cnt + 1'b1;
        if (sweep_cnt == SWEEP_W'(SWEEP_LEN - 1)) init_done_o <= 1'b1;
      end
      // pointer moves on every miss fill
      if (commit_i && !hit_o) begin
        rr_q <= {rr_q[NUM_WAYS-2:0], rr_q[NUM_WAYS-1]};
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // array writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!init_done_o) begin
      // one set cleared per cycle
      valid_q[sweep_idx] <= '0;
      dirty_q[sweep_idx] <= '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        tag_q[sweep_idx][w] <= '0;
      end
    end else if (commit_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (way_o[w]) begin
          if (hit_o) begin
            // line present, a write only sets dirty
            dirty_q[req_index_q][w] <= dirty_q[req_index_q][w] | req_dirty_q;
          end else begin
            tag_q[req_index_q][w]   <= req_tag_q;
            valid_q[req_index_q][w] <= 1'b1;
            dirty_q[req_index_q][w] <= req_dirty_q;
          end
        end
      end
    end
  end

endmodule

// ==== rtl/miss_counters.sv ====
module miss_counters import hit_miss_pkg::*; #(
  parameter int unsigned NUM_IDS = 4
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic cnt_up_i,
  input  id_t  cnt_id_i,
  input  logic cnt_down_i,
  input  id_t  cnt_down_id_i,
  output logic to_miss_o,
  output logic full_o
);

  localparam cnt_t CNT_MAX = '1;

  cnt_t               cnt_q [NUM_IDS];
  cnt_t               cur_cnt;
  logic [NUM_IDS-1:0] up_sel;
  logic [NUM_IDS-1:0] down_sel;

  // decode up and down strobes per id, and pick the queried counter
  always_comb begin
    cur_cnt = '0;
    for (int i = 0; i < NUM_IDS; i++) begin
      up_sel[i]   = cnt_up_i && (cnt_id_i == id_t'(i));
      down_sel[i] = cnt_down_i && (cnt_down_id_i == id_t'(i));
      if (cnt_id_i == id_t'(i)) cur_cnt = cnt_q[i];
    end
  end

  // saturating in both directions, simultaneous up and down cancel
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_IDS; i++) cnt_q[i] <= '0;
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        if (up_sel[i] && !down_sel[i] && (cnt_q[i] != CNT_MAX)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (down_sel[i] && !up_sel[i] && (cnt_q[i] != '0)) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // misses outstanding, hits must follow them
  assign to_miss_o = |cur_cnt;
  assign full_o    = (cur_cnt == CNT_MAX);

endmodule

// ==== rtl/lock_table.sv ====
module lock_table import hit_miss_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  // lock request from the controller, also the query
  input  logic   lock_set_i,
  input  index_t lock_index_i,
  input  way_t   lock_way_i,
  // single unlock channel
  input  logic   unlock_req_i,
  input  index_t unlock_index_i,
  input  way_t   unlock_way_i,
  output logic   locked_o,
  output logic   unlock_gnt_o
);

  // one bit per set and way
  way_t lock_q [NUM_SETS];

  // line still in use downstream
  assign locked_o = |(lock_q[lock_index_i] & lock_way_i);

  // a lock set takes the cycle, the unlock retries
  assign unlock_gnt_o = unlock_req_i & ~lock_set_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int s = 0; s < NUM_SETS; s++) lock_q[s] <= '0;
    end else begin
      for (int s = 0; s < NUM_SETS; s++) begin
        if (lock_set_i && (lock_index_i == index_t'(s))) begin
          lock_q[s] <= lock_q[s] | lock_way_i;
        end else if (unlock_gnt_o && (unlock_index_i == index_t'(s))) begin
          lock_q[s] <= lock_q[s] & ~unlock_way_i;
        end
      end
    end
  end

endmodule

// ==== rtl/hit_miss_top.sv ====
module hit_miss_top import hit_miss_pkg::*; #(
  parameter int unsigned NUM_IDS   = 4,
  parameter int unsigned SWEEP_LEN = 16
) (
  input  logic   clk_i,
  input  logic   rst_i,
  // descriptor in
  input  logic   valid_i,
  input  addr_t  addr_i,
  input  id_t    id_i,
  input  logic   rw_i,
  output logic   ready_o,
  // descriptor out
  output logic   hit_valid_o,
  input  logic   hit_ready_i,
  output logic   miss_valid_o,
  input  logic   miss_ready_i,
  output addr_t  out_addr_o,
  output id_t    out_id_o,
  output logic   out_rw_o,
  output way_t   way_o,
  output logic   refill_o,
  output logic   evict_o,
  output tag_t   evict_tag_o,
  // unlock channel
  input  logic   unlock_req_i,
  input  index_t unlock_index_i,
  input  way_t   unlock_way_i,
  output logic   unlock_gnt_o,
  // miss counter release
  input  logic   cnt_down_i,
  input  id_t    cnt_down_id_i
);

  //////////////////////////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////////////////////////

  // controller to tag store
  logic   lookup;
  index_t ts_index;
  tag_t   ts_tag;
  logic   ts_dirty;
  logic   commit;
  logic   init_done;
  way_t   ts_way;
  logic   ts_hit;
  logic   ts_evict;
  tag_t   ts_evict_tag;
  // controller to lock table
  logic   lock_set;
  index_t lock_index;
  way_t   lock_way;
  logic   locked;
  // controller to miss counters
  logic   cnt_up;
  id_t    cnt_id;
  logic   to_miss;
  logic   cnt_full;

  hit_miss_ctrl i_ctrl (
    .clk_i, .rst_i, .valid_i, .addr_i, .id_i, .rw_i, .ready_o,
    .hit_valid_o, .hit_ready_i, .miss_valid_o, .miss_ready_i,
    .out_addr_o, .out_id_o, .out_rw_o, .way_o, .refill_o, .evict_o, .evict_tag_o,
    .init_done_i  (init_done),
    .way_i        (ts_way),
    .hit_i        (ts_hit),
    .evict_i      (ts_evict),
    .evict_tag_i  (ts_evict_tag),
    .lookup_o     (lookup),
    .index_o      (ts_index),
    .tag_o        (ts_tag),
    .dirty_o      (ts_dirty),
    .commit_o     (commit),
    .locked_i     (locked),
    .lock_set_o   (lock_set),
    .lock_index_o (lock_index),
    .lock_way_o   (lock_way),
    .to_miss_i    (to_miss),
    .full_i       (cnt_full),
    .cnt_up_o     (cnt_up),
    .cnt_id_o     (cnt_id)
  );

  tag_store #(.SWEEP_LEN(SWEEP_LEN)) i_tag_store (
    .clk_i, .rst_i,
    .lookup_i    (lookup),
    .index_i     (ts_index),
    .tag_i       (ts_tag),
    .dirty_i     (ts_dirty),
    .commit_i    (commit),
    .init_done_o (init_done),
    .way_o       (ts_way),
    .hit_o       (ts_hit),
    .evict_o     (ts_evict),
    .evict_tag_o (ts_evict_tag)
  );

  miss_counters #(.NUM_IDS(NUM_IDS)) i_miss_counters (
    .clk_i, .rst_i, .cnt_down_i, .cnt_down_id_i,
    .cnt_up_i  (cnt_up),
    .cnt_id_i  (cnt_id),
    .to_miss_o (to_miss),
    .full_o    (cnt_full)
  );

  lock_table i_lock_table (
    .clk_i, .rst_i, .unlock_req_i, .unlock_index_i, .unlock_way_i, .unlock_gnt_o,
    .lock_set_i   (lock_set),
    .lock_index_i (lock_index),
    .lock_way_i   (lock_way),
    .locked_o     (locked)
  );

endmodule

// ==== verif/hit_miss_assert.sv ====
module hit_miss_assert import hit_miss_pkg::*; (
  input logic clk_i,
  input logic rst_i,
  input logic ready_i,
  input logic hit_valid_i,
  input logic miss_valid_i,
  input way_t way_i,
  input logic init_done_i
);

  //////////////////////////////////////////////////////////////////////
  // hand-off checks
  //////////////////////////////////////////////////////////////////////

  // a descriptor goes to one path only
  a_one_path: assert property (@(posedge clk_i) disable iff (rst_i)
    !(hit_valid_i && miss_valid_i))
    else $error("hit and miss valid outputs high in the same cycle");

  // way select stays one-hot while a descriptor is offered
  a_way_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    (hit_valid_i || miss_valid_i) |-> $onehot(way_i))
    else $error("way output not one-hot during hand-off");

  // no acceptance during the tag clear sweep
  a_ready_init: assert property (@(posedge clk_i) disable iff (rst_i)
    !init_done_i |-> !ready_i)
    else $error("ready high before the tag store finished init");

endmodule

// ==== verif/tb_hit_miss.sv ====
module tb_hit_miss import hit_miss_pkg::*; ();

  localparam int unsigned NUM_IDS    = 4;
  localparam int unsigned SWEEP_LEN  = 16;
  localparam int          RST_CYCLES = 10;
  localparam int          DRV_DLY    = 10;

  // table shorthands
  localparam logic       RD     = 1'b0;
  localparam logic       WR     = 1'b1;
  localparam logic       HIT    = 1'b1;
  localparam logic       MISS   = 1'b0;
  localparam way_t       W0     = 2'b01;
  localparam way_t       W1     = 2'b10;
  localparam logic [1:0] S_NONE = 2'd0;
  localparam logic [1:0] S_LOCK = 2'd1;
  localparam logic [1:0] S_CNT  = 2'd2;

  // one stimulus row with its hand-worked expectation
  typedef struct packed {
    addr_t      addr;
    id_t        id;
    logic       rw;
    logic       bp;
    logic       unlock;
    logic [1:0] n_down;
    logic [1:0] stall;
    logic       route;
    way_t       way;
    logic       refill;
    logic       evict;
    tag_t       tag;
  } row_t;

  logic   clk_i, rst_i;
  logic   valid_i, rw_i, ready_o;
  addr_t  addr_i;
  id_t    id_i;
  logic   hit_valid_o, hit_ready_i, miss_valid_o, miss_ready_i;
  addr_t  out_addr_o;
  id_t    out_id_o;
  logic   out_rw_o, refill_o, evict_o;
  way_t   way_o;
  tag_t   evict_tag_o;
  logic   unlock_req_i, unlock_gnt_o;
  index_t unlock_index_i;
  way_t   unlock_way_i;
  logic   cnt_down_i;
  id_t    cnt_down_id_i;

  row_t   rows [$];
  int     err_cnt = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     cycle_cnt = 0;
  int     max_cycles = 0;
  int     cur_row = 0;
  integer seed;
  // line left locked by a row without unlock
  index_t pend_idx;
  way_t   pend_way;

  hit_miss_top #(.NUM_IDS(NUM_IDS), .SWEEP_LEN(SWEEP_LEN)) i_dut (.*);

  bind hit_miss_top hit_miss_assert i_assert (
    .clk_i(clk_i), .rst_i(rst_i), .ready_i(ready_o), .hit_valid_i(hit_valid_o),
    .miss_valid_i(miss_valid_o), .way_i(way_o), .init_done_i(init_done)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // watchdog with its limit set from the table length
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles, stuck in row %0d",
               max_cycles, cur_row);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #DRV_DLY;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      err_cnt++;
      $display("FAIL t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic add_row(input addr_t addr, input id_t id, input logic rw, input logic bp,
                         input logic unlock, input logic [1:0] n_down,
                         input logic [1:0] stall, input logic route, input way_t way,
                         input logic refill, input logic evict, input tag_t tag);
    rows.push_back({addr, id, rw, bp, unlock, n_down, stall, route, way, refill, evict, tag});
  endtask

  // addr, id, rw, back-pressure, unlock, count-downs, stall, route, way, refill, evict, tag
  task automatic build_table();
    // first touches miss into the lowest free way
    add_row(16'h1230, 2'd0, RD, 1'b0, 1'b1, 2'd1, S_NONE, MISS, W0, 1'b1, 1'b0, 8'h00);
    add_row(16'h1234, 2'd0, RD, 1'b1, 1'b1, 2'd0, S_NONE, HIT,  W0, 1'b0, 1'b0, 8'h00);
    add_row(16'h4550, 2'd1, RD, 1'b0, 1'b1, 2'd0, S_NONE, MISS, W0, 1'b1, 1'b0, 8'h00);
    // id 1 miss still pending so the hit is forced onto the miss path
    add_row(16'h4558, 2'd1, RD, 1'b0, 1'b1, 2'd2, S_NONE, MISS, W0, 1'b0, 1'b0, 8'h00);
    // set 7 filled with writes and then evicted round robin
    add_row(16'ha070, 2'd2, WR, 1'b0, 1'b1, 2'd1, S_NONE, MISS, W0, 1'b1, 1'b0, 8'h00);
    add_row(16'hb070, 2'd2, WR, 1'b0, 1'b1, 2'd1, S_NONE, MISS, W1, 1'b1, 1'b0, 8'h00);
    add_row(16'hc070, 2'd2, RD, 1'b0, 1'b1, 2'd1, S_NONE, MISS, W0, 1'b1, 1'b1, 8'ha0);
    add_row(16'hd070, 2'd3, RD, 1'b1, 1'b1, 2'd1, S_NONE, MISS, W1, 1'b1, 1'b1, 8'hb0);
    // write hit dirties way 0 and makes its eviction below dirty
    add_row(16'hc07c, 2'd3, WR, 1'b0, 1'b1, 2'd0, S_NONE, HIT,  W0, 1'b0, 1'b0, 8'h00);
    add_row(16'he070, 2'd0, RD, 1'b0, 1'b1, 2'd1, S_NONE, MISS, W0, 1'b1, 1'b1, 8'hc0);
    // line left locked so the next access waits for the unlock
    add_row(16'he074, 2'd0, RD, 1'b0, 1'b0, 2'd0, S_NONE, HIT,  W0, 1'b0, 1'b0, 8'h00);
    add_row(16'he078, 2'd1, RD, 1'b0, 1'b1, 2'd0, S_LOCK, HIT,  W0, 1'b0, 1'b0, 8'h00);
    // three id 1 misses fill its counter
    add_row(16'h2110, 2'd1, RD, 1'b0, 1'b1, 2'd0, S_NONE, MISS, W0, 1'b1, 1'b0, 8'h00);
    add_row(16'h3110, 2'd1, RD, 1'b1, 1'b1, 2'd0, S_NONE, MISS, W1, 1'b1, 1'b0, 8'h00);
    add_row(16'h4210, 2'd1, WR, 1'b0, 1'b1, 2'd0, S_NONE, MISS, W1, 1'b1, 1'b0, 8'h31);
    add_row(16'h2118, 2'd1, RD, 1'b0, 1'b1, 2'd3, S_CNT,  MISS, W0, 1'b0, 1'b0, 8'h00);
    add_row(16'h4214, 2'd1, RD, 1'b0, 1'b1, 2'd0, S_NONE, HIT,  W1, 1'b0, 1'b0, 8'h00);
  endtask

  // offer a descriptor and hold it until the edge that takes it
  task automatic send_desc(input addr_t addr, input id_t id, input logic rw);
    logic taken;
    valid_i = 1'b1;
    addr_i  = addr;
    id_i    = id;
    rw_i    = rw;
    #1;
    taken = ready_o;
    while (!taken) begin
      next_cycle();
      #1;
      taken = ready_o;
    end
    next_cycle();
    valid_i = 1'b0;
  endtask

  // returns in the cycle where a valid output is up as sampled 1 after the drive point
  task automatic wait_valid(output int waited);
    waited = 0;
    #1;
    while (!(hit_valid_o || miss_valid_o)) begin
      waited++;
      next_cycle();
      #1;
    end
  endtask

  task automatic release_line(input index_t idx, input way_t way);
    logic granted;
    unlock_req_i   = 1'b1;
    unlock_index_i = idx;
    unlock_way_i   = way;
    #1;
    granted = unlock_gnt_o;
    // no hand-off happens in this cycle and the grant comes with the request
    check_value("unlock_gnt_o", 32'(unlock_gnt_o), 32'h1);
    // a refused unlock stays asserted
    while (!granted) begin
      next_cycle();
      #1;
      granted = unlock_gnt_o;
    end
    next_cycle();
    unlock_req_i = 1'b0;
  endtask

  task automatic pulse_cnt_down(input id_t id);
    cnt_down_i    = 1'b1;
    cnt_down_id_i = id;
    next_cycle();
    cnt_down_i = 1'b0;
  endtask

  task automatic check_outputs(input row_t r);
    check_value("hit_valid_o", 32'(hit_valid_o), 32'(r.route));
    check_value("miss_valid_o", 32'(miss_valid_o), 32'(!r.route));
    check_value("out_addr_o", 32'(out_addr_o), 32'(r.addr));
    check_value("out_id_o", 32'(out_id_o), 32'(r.id));
    check_value("out_rw_o", 32'(out_rw_o), 32'(r.rw));
    check_value("way_o", 32'(way_o), 32'(r.way));
    check_value("refill_o", 32'(refill_o), 32'(r.refill));
    check_value("evict_o", 32'(evict_o), 32'(r.evict));
    check_value("evict_tag_o", 32'(evict_tag_o), 32'(r.tag));
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic check_sweep();
    int   low_cycles;
    logic seen;
    low_cycles = 0;
    valid_i    = 1'b1;
    addr_i     = 16'h0000;
    #1;
    seen = ready_o;
    while (!seen) begin
      low_cycles++;
      next_cycle();
      #1;
      seen = ready_o;
    end
    // probe withdrawn before the edge so nothing gets accepted
    valid_i = 1'b0;
    tests_run++;
    if (low_cycles < int'(SWEEP_LEN)) begin
      err_cnt++;
      tests_failed++;
      $display("sweep: ready_o rose after %0d cycles, before the %0d-cycle clear ended",
               low_cycles, SWEEP_LEN);
    end else begin
      $display("sweep: passed, ready_o low for %0d cycles", low_cycles);
    end
    next_cycle();
  endtask

  task automatic run_row(input int n, input row_t r);
    int errs_before;
    int hold;
    int waited;
    errs_before  = err_cnt;
    hit_ready_i  = ~r.bp;
    miss_ready_i = ~r.bp;
    send_desc(r.addr, r.id, r.rw);
    if (r.stall != S_NONE) begin
      // lookup cycle plus at least one stalled route cycle
      hold = 2 + ($random(seed) & 3);
      repeat (hold) begin
        #1;
        check_value("hit_valid_o", 32'(hit_valid_o), 32'h0);
        check_value("miss_valid_o", 32'(miss_valid_o), 32'h0);
        next_cycle();
      end
      if (r.stall == S_LOCK) begin
        release_line(pend_idx, pend_way);
      end else begin
        pulse_cnt_down(r.id);
      end
    end
    wait_valid(waited);
    if (r.stall == S_NONE && waited == 0) begin
      err_cnt++;
      $display("row %0d: valid output came in the lookup cycle, one cycle early", n);
    end
    check_outputs(r);
    if (r.bp) begin
      // outputs must hold while the path is not ready
      hold = 1 + ($random(seed) & 3);
      repeat (hold) begin
        next_cycle();
        #1;
        check_outputs(r);
      end
      next_cycle();
      hit_ready_i  = 1'b1;
      miss_ready_i = 1'b1;
    end
    // transfer edge
    next_cycle();
    if (r.unlock) begin
      release_line(r.addr[OFFSET_W +: INDEX_W], r.way);
    end else begin
      pend_idx = r.addr[OFFSET_W +: INDEX_W];
      pend_way = r.way;
    end
    repeat (r.n_down) pulse_cnt_down(r.id);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("row %0d: %s 0x%h id %0d -> %s, passed", n, r.rw ? "wr" : "rd",
               r.addr, r.id, r.route ? "hit" : "miss");
    end else begin
      tests_failed++;
      $display("row %0d: %s 0x%h id %0d -> %s, failed with %0d mismatches", n,
               r.rw ? "wr" : "rd", r.addr, r.id, r.route ? "hit" : "miss",
               err_cnt - errs_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed           = 32'hfb83_0385;
    rst_i          = 1'b1;
    valid_i        = 1'b0;
    addr_i         = '0;
    id_i           = '0;
    rw_i           = 1'b0;
    hit_ready_i    = 1'b1;
    miss_ready_i   = 1'b1;
    unlock_req_i   = 1'b0;
    unlock_index_i = '0;
    unlock_way_i   = '0;
    cnt_down_i     = 1'b0;
    cnt_down_id_i  = '0;
    pend_idx       = '0;
    pend_way       = '0;
    build_table();
    max_cycles = SWEEP_LEN + 40 * rows.size();
    repeat (RST_CYCLES) @(posedge clk_i);
    #DRV_DLY;
    rst_i = 1'b0;
    check_sweep();
    foreach (rows[i]) begin
      cur_row = i + 1;
      run_row(i + 1, rows[i]);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d mismatches", tests_run,
             tests_run - tests_failed, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
rtl/hit_miss_pkg.sv
rtl/hit_miss_ctrl.sv
rtl/tag_store.sv
rtl/miss_counters.sv
rtl/lock_table.sv
rtl/hit_miss_top.sv
verif/hit_miss_assert.sv
verif/tb_hit_miss.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the hit/miss unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f compile.f --top-module tb_hit_miss \
  -Mdir "$OBJ" -o Vtb_hit_miss
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_hit_miss" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
